// File: cpu_pkg.sv
/* Shared types for the 6502-style core: data and address words, microcode
   states, ALU operations, register selects and the zero-page constant */
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;    // Data bus, registers, ALU operands
    typedef logic [15:0] addr_t;    // Full bus address

    // Microcode states, one path per addressing mode
    typedef enum logic [3:0] {
        DECODE,                     // Opcode on di, write back previous result
        FETCH,                      // Read operand or next opcode, run ALU
        REG,                        // Implied and register transfers
        ZP0,                        // Zero-page read or write
        JMP0,                       // Target low byte
        JMP1,                       // Target high byte
        BRA0,                       // Offset plus PCL
        BRA1,                       // Fix up high byte
        BRA2,                       // Extra cycle on page cross
        VEC0                        // Present reset vector
    } state_t;

    typedef enum logic [2:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_ADD,
        OP_SUB,                     // A + ~B + carry
        OP_A                        // Pass A operand
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y
    } reg_sel_t;

    localparam byte_t ZERO_PAGE = 8'h00;   // High byte of zero-page accesses

endpackage

`default_nettype wire

// File: instr_decode.sv
/* Parallel instruction decoder, latches control fields for the
   opcode leaving DECODE and the branch direction in BRA0 */
`default_nettype none

module instr_decode (
    input  wire                    clk,
    input  wire cpu_pkg::state_t   state,
    input  wire cpu_pkg::byte_t    di,
    output logic                   load_reg,
    output logic                   store,
    output logic                   load_only,
    output logic                   compare,
    output logic                   adc_sbc,
    output logic                   inc,
    output logic                   clc,
    output logic                   sec,
    output cpu_pkg::reg_sel_t      src_reg,
    output cpu_pkg::reg_sel_t      dst_reg,
    output cpu_pkg::alu_op_t       op,
    output logic [2:0]             cond_code,
    output logic                   backwards
);

    // Low two opcode bits of LDx/STx: 00 Y, 01 A, 10 X
    function automatic cpu_pkg::reg_sel_t col_sel(input logic [1:0] b);
        return b[1] ? cpu_pkg::SEL_X : (b[0] ? cpu_pkg::SEL_A : cpu_pkg::SEL_Y);
    endfunction

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::DECODE) begin
            load_reg  <= 1'b0;
            store     <= 1'b0;
            load_only <= 1'b0;
            compare   <= 1'b0;
            adc_sbc   <= 1'b0;
            inc       <= 1'b0;
            src_reg   <= cpu_pkg::SEL_A;
            dst_reg   <= cpu_pkg::SEL_A;
            op        <= cpu_pkg::OP_ADD;
            clc       <= (di == 8'h18);
            sec       <= (di == 8'h38);
            cond_code <= di[7:5];               // Flag select and polarity
            casez (di)
                8'b0??0_0101,
                8'b0??0_1001: begin             // ORA, AND, EOR, ADC
                    load_reg <= 1'b1;
                    adc_sbc  <= (di[6:5] == 2'b11);
                    case (di[6:5])
                        2'b00:   op <= cpu_pkg::OP_OR;
                        2'b01:   op <= cpu_pkg::OP_AND;
                        2'b10:   op <= cpu_pkg::OP_EOR;
                        default: op <= cpu_pkg::OP_ADD;
                    endcase
                end
                8'b1110_0101,
                8'b1110_1001: begin             // SBC
                    load_reg <= 1'b1;
                    adc_sbc  <= 1'b1;
                    op       <= cpu_pkg::OP_SUB;
                end
                8'b1100_0101,
                8'b1100_1001: begin             // CMP, flags only
                    compare <= 1'b1;
                    op      <= cpu_pkg::OP_SUB;
                end
                8'b1000_01??: begin             // STY, STA, STX
                    store   <= 1'b1;
                    src_reg <= col_sel(di[1:0]);
                    op      <= cpu_pkg::OP_A;
                end
                8'b1010_01??,
                8'b1010_00?0,
                8'b1010_1001: begin             // LDA, LDX, LDY
                    load_reg  <= 1'b1;
                    load_only <= 1'b1;
                    dst_reg   <= col_sel(di[1:0]);
                end
                8'b11?0_1000: begin             // INY, INX
                    load_reg <= 1'b1;
                    inc      <= 1'b1;
                    src_reg  <= di[5] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                    dst_reg  <= di[5] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                end
                8'b1100_1010,
                8'b1000_1000: begin             // DEX, DEY
                    load_reg <= 1'b1;
                    op       <= cpu_pkg::OP_SUB;
                    src_reg  <= di[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                    dst_reg  <= di[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                end
                8'b1010_10?0: begin             // TAY, TAX
                    load_reg <= 1'b1;
                    dst_reg  <= di[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                end
                8'b1000_1010,
                8'b1001_1000: begin             // TXA, TYA
                    load_reg <= 1'b1;
                    src_reg  <= di[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                end
                default: ;                      // Branches, JMP, flag ops, no-ops
            endcase
        end
        if (state == cpu_pkg::BRA0) begin
            backwards <= di[7];                 // Sign of branch offset
        end
    end

endmodule

`default_nettype wire

// File: cpu_sequencer.sv
/* Microcode state machine: mode select from the opcode in DECODE,
   fixed paths for zero page, jump, branch and reset vector */
`default_nettype none

module cpu_sequencer (
    input  wire                  clk,
    input  wire                  reset,
    input  wire cpu_pkg::byte_t  di,
    input  wire                  co,
    input  wire                  backwards,
    input  wire                  cond_true,
    output cpu_pkg::state_t      state
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::VEC0;
        end else begin
            case (state)
                cpu_pkg::DECODE: begin
                    casez (di)
                        8'b0100_1100: state <= cpu_pkg::JMP0;     // JMP abs
                        8'b???1_0000: state <= cpu_pkg::BRA0;     // Eight branches
                        8'b???0_0101,
                        8'b10?0_01?0: state <= cpu_pkg::ZP0;      // Zero-page column
                        8'b???0_1001,
                        8'b1010_00?0: state <= cpu_pkg::FETCH;    // Immediate
                        default:      state <= cpu_pkg::REG;      // Implied, unsupported
                    endcase
                end
                cpu_pkg::VEC0:  state <= cpu_pkg::JMP0;           // Vector read as a jump
                cpu_pkg::ZP0:   state <= cpu_pkg::FETCH;
                cpu_pkg::FETCH: state <= cpu_pkg::DECODE;
                cpu_pkg::REG:   state <= cpu_pkg::DECODE;
                cpu_pkg::JMP0:  state <= cpu_pkg::JMP1;
                cpu_pkg::JMP1:  state <= cpu_pkg::DECODE;
                cpu_pkg::BRA0:  state <= cond_true ? cpu_pkg::BRA1 : cpu_pkg::DECODE;
                // Carry disagrees with offset sign on a page cross
                cpu_pkg::BRA1:  state <= (co ^ backwards) ? cpu_pkg::BRA2 : cpu_pkg::DECODE;
                cpu_pkg::BRA2:  state <= cpu_pkg::DECODE;
                default:        state <= cpu_pkg::DECODE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: address_unit.sv
/* Program counter, held address register and address-bus multiplexer */
`default_nettype none

module address_unit #(
    parameter cpu_pkg::addr_t RESET_VECTOR = 16'hfffc
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire cpu_pkg::state_t  state,
    input  wire cpu_pkg::byte_t   di,
    input  wire cpu_pkg::byte_t   alu_out,
    input  wire                   co,
    input  wire                   backwards,
    output cpu_pkg::addr_t        ab,
    output cpu_pkg::byte_t        pcl,
    output cpu_pkg::byte_t        abh
);

    cpu_pkg::addr_t pc;
    cpu_pkg::addr_t pc_temp;        // Base value before increment
    logic           pc_inc;
    cpu_pkg::byte_t abl;

    assign pcl = pc[7:0];

    always_comb begin
        case (state)
            cpu_pkg::VEC0: begin
                pc_temp = RESET_VECTOR;
                pc_inc  = 1'b1;
            end
            cpu_pkg::DECODE,
            cpu_pkg::FETCH,
            cpu_pkg::BRA0: begin
                pc_temp = pc;
                pc_inc  = 1'b1;
            end
            cpu_pkg::JMP1: begin
                pc_temp = {di, alu_out};                // High from bus, low from ALU
                pc_inc  = 1'b1;
            end
            cpu_pkg::BRA1: begin
                pc_temp = {abh, alu_out};
                pc_inc  = co ~^ backwards;              // Same page, target done
            end
            cpu_pkg::BRA2: begin
                pc_temp = {alu_out, pc[7:0]};           // Corrected high byte
                pc_inc  = 1'b1;
            end
            default: begin
                pc_temp = pc;
                pc_inc  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= pc_temp + {15'd0, pc_inc};
        end
    end

    always_comb begin
        case (state)
            cpu_pkg::VEC0: ab = RESET_VECTOR;
            cpu_pkg::JMP1: ab = {di, alu_out};
            cpu_pkg::BRA1: ab = {abh, alu_out};
            cpu_pkg::BRA2: ab = {alu_out, abl};
            cpu_pkg::ZP0:  ab = {cpu_pkg::ZERO_PAGE, di};
            cpu_pkg::REG:  ab = {abh, abl};             // Re-read next opcode
            default:       ab = pc;
        endcase
    end

    // Previous bus address, kept for the branch fix-up
    always_ff @(posedge clk) begin
        abl <= ab[7:0];
        abh <= ab[15:8];
    end

endmodule

`default_nettype wire

// File: alu.sv
/* Registered 8-bit ALU with state-driven operand and carry-in selection */
`default_nettype none

module alu (
    input  wire                    clk,
    input  wire cpu_pkg::state_t   state,
    input  wire cpu_pkg::alu_op_t  op,
    input  wire cpu_pkg::byte_t    regfile,
    input  wire cpu_pkg::byte_t    di,
    input  wire cpu_pkg::byte_t    pcl,
    input  wire cpu_pkg::byte_t    abh,
    input  wire                    backwards,
    input  wire                    load_only,
    input  wire                    compare,
    input  wire                    inc,
    input  wire                    c,
    output cpu_pkg::byte_t         alu_out,
    output logic                   co,
    output logic                   av,
    output logic                   az,
    output logic                   an
);

    cpu_pkg::byte_t   ai;
    cpu_pkg::byte_t   bi;
    cpu_pkg::byte_t   bx;          // B operand, inverted for subtract
    logic             ci;
    cpu_pkg::alu_op_t alu_op;      // Operation for this cycle
    logic [8:0]       sum;
    logic [8:0]       res;

    always_comb begin
        case (state)
            cpu_pkg::REG:   ai = regfile;
            cpu_pkg::BRA0:  ai = di;                            // Branch offset
            cpu_pkg::BRA1:  ai = abh;
            cpu_pkg::FETCH: ai = load_only ? 8'h00 : regfile;
            default:        ai = 8'h00;
        endcase
        case (state)
            cpu_pkg::REG,
            cpu_pkg::BRA1:  bi = 8'h00;
            cpu_pkg::BRA0:  bi = pcl;
            default:        bi = di;
        endcase
        case (state)
            cpu_pkg::BRA1:  ci = co;                            // Carry from low-byte add
            cpu_pkg::REG:   ci = inc;
            cpu_pkg::FETCH: ci = compare | (~load_only & c);
            default:        ci = 1'b0;
        endcase
        case (state)
            cpu_pkg::FETCH,
            cpu_pkg::REG:   alu_op = op;
            cpu_pkg::BRA1:  alu_op = backwards ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD;
            default:        alu_op = cpu_pkg::OP_ADD;
        endcase
    end

    always_comb begin
        bx  = (alu_op == cpu_pkg::OP_SUB) ? ~bi : bi;
        sum = {1'b0, ai} + {1'b0, bx} + {8'd0, ci};
        case (alu_op)
            cpu_pkg::OP_OR:  res = {1'b0, ai | bi};
            cpu_pkg::OP_AND: res = {1'b0, ai & bi};
            cpu_pkg::OP_EOR: res = {1'b0, ai ^ bi};
            cpu_pkg::OP_A:   res = {1'b0, ai};
            default:         res = sum;                         // Add and subtract
        endcase
    end

    always_ff @(posedge clk) begin
        alu_out <= res[7:0];
        co      <= res[8];
        av      <= (ai[7] == bx[7]) && (sum[7] != ai[7]);       // Signed overflow
        az      <= (res[7:0] == 8'h00);
        an      <= res[7];
    end

endmodule

`default_nettype wire

// File: reg_file.sv
/* A/X/Y register file, N/V/Z/C flags, branch condition and store data */
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     reset,
    input  wire cpu_pkg::state_t    state,
    input  wire                     load_reg,
    input  wire                     store,
    input  wire cpu_pkg::reg_sel_t  src_reg,
    input  wire cpu_pkg::reg_sel_t  dst_reg,
    input  wire                     adc_sbc,
    input  wire                     compare,
    input  wire                     clc,
    input  wire                     sec,
    input  wire [2:0]               cond_code,
    input  wire cpu_pkg::byte_t     alu_out,
    input  wire                     co,
    input  wire                     av,
    input  wire                     az,
    input  wire                     an,
    output cpu_pkg::byte_t          regfile,
    output logic                    c,
    output logic                    cond_true,
    output cpu_pkg::byte_t          data_out
);

    cpu_pkg::byte_t    axy [3];        // Indexed by reg_sel_t
    cpu_pkg::reg_sel_t regsel;
    logic              write_register;
    logic              n;
    logic              v;
    logic              z;

    // Previous instruction writes back while next opcode decodes
    assign write_register = (state == cpu_pkg::DECODE) && load_reg;
    assign regsel         = (state == cpu_pkg::DECODE) ? dst_reg : src_reg;
    assign regfile        = axy[regsel];
    assign data_out       = store ? axy[src_reg] : 8'h00;     // Bus idles at zero

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                axy[i] <= 8'h00;
            end
        end else if (write_register) begin
            axy[dst_reg] <= alu_out;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            n <= 1'b0;
            v <= 1'b0;
            z <= 1'b0;
            c <= 1'b0;
        end else if (state == cpu_pkg::DECODE) begin
            if (adc_sbc || compare) begin
                c <= co;                            // Borrow is inverted carry
            end else if (sec) begin
                c <= 1'b1;
            end else if (clc) begin
                c <= 1'b0;
            end
            if (load_reg || compare) begin
                z <= az;
                n <= an;
            end
            if (adc_sbc) begin
                v <= av;
            end
        end
    end

    // Opcode bits 7:6 pick the flag, bit 5 the polarity
    always_comb begin
        case (cond_code)
            3'b000:  cond_true = ~n;                // BPL
            3'b001:  cond_true = n;                 // BMI
            3'b010:  cond_true = ~v;                // BVC
            3'b011:  cond_true = v;                 // BVS
            3'b100:  cond_true = ~c;                // BCC
            3'b101:  cond_true = c;                 // BCS
            3'b110:  cond_true = ~z;                // BNE
            default: cond_true = z;                 // BEQ
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_top.sv
/* Core top level: sequencer, decoder, address unit, ALU and register file */
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::addr_t RESET_VECTOR = 16'hfffc
) (
    input  wire                  clk,
    input  wire                  reset,
    output cpu_pkg::addr_t       ab,
    input  wire cpu_pkg::byte_t  di,
    output cpu_pkg::byte_t       data_out,
    output logic                 we
);

    cpu_pkg::state_t   state;
    logic              load_reg;
    logic              store;
    logic              load_only;
    logic              compare;
    logic              adc_sbc;
    logic              inc;
    logic              clc;
    logic              sec;
    cpu_pkg::reg_sel_t src_reg;
    cpu_pkg::reg_sel_t dst_reg;
    cpu_pkg::alu_op_t  op;
    logic [2:0]        cond_code;
    logic              backwards;
    cpu_pkg::byte_t    alu_out;
    logic              co;
    logic              av;
    logic              az;
    logic              an;
    cpu_pkg::byte_t    regfile;
    logic              c;
    logic              cond_true;
    cpu_pkg::byte_t    pcl;
    cpu_pkg::byte_t    abh;

    assign we = (state == cpu_pkg::ZP0) && store;     // Only zero-page stores write

    cpu_sequencer i_cpu_sequencer (
        .clk, .reset, .di, .co, .backwards, .cond_true, .state
    );

    instr_decode i_instr_decode (
        .clk, .state, .di, .load_reg, .store, .load_only, .compare, .adc_sbc,
        .inc, .clc, .sec, .src_reg, .dst_reg, .op, .cond_code, .backwards
    );

    address_unit #(
        .RESET_VECTOR(RESET_VECTOR)
    ) i_address_unit (
        .clk, .reset, .state, .di, .alu_out, .co, .backwards, .ab, .pcl, .abh
    );

    alu i_alu (
        .clk, .state, .op, .regfile, .di, .pcl, .abh, .backwards, .load_only,
        .compare, .inc, .c, .alu_out, .co, .av, .az, .an
    );

    reg_file i_reg_file (
        .clk, .reset, .state, .load_reg, .store, .src_reg, .dst_reg, .adc_sbc,
        .compare, .clc, .sec, .cond_code, .alu_out, .co, .av, .az, .an,
        .regfile, .c, .cond_true, .data_out
    );

endmodule

`default_nettype wire

// File: tb_model.svh
/* Instruction-level reference model: runs the program image and queues
   the expected zero-page writes */

cpu_pkg::byte_t ref_mem [0:65535];     // Private copy of the image
cpu_pkg::byte_t ma, mx, my;             // Model registers
logic           mn, mv, mz, mc;         // Model flags

task automatic set_nz(input cpu_pkg::byte_t r);
    mn = r[7];
    mz = (r == 8'h00);
endtask

// ADC core, SBC passes the inverted operand
task automatic add_carry(input cpu_pkg::byte_t b);
    logic [8:0] s;
    s  = {1'b0, ma} + {1'b0, b} + {8'd0, mc};
    mv = (ma[7] == b[7]) && (s[7] != ma[7]);
    mc = s[8];
    ma = s[7:0];
    set_nz(ma);
endtask

task automatic store_byte(input cpu_pkg::byte_t zp, input cpu_pkg::byte_t r);
    ref_mem[{8'h00, zp}] = r;
    exp_addr.push_back({8'h00, zp});
    exp_data.push_back(r);
endtask

task automatic run_model();
    cpu_pkg::addr_t pc;
    cpu_pkg::byte_t opc;
    cpu_pkg::byte_t opd;
    cpu_pkg::byte_t val;
    logic [8:0]     s;
    logic           flag;
    int             steps;
    bit             done;
    pc    = 16'h02f0;
    done  = 1'b0;
    steps = 0;
    {ma, mx, my} = 24'h0;               // Matches register reset
    {mn, mv, mz, mc} = 4'h0;
    while (!done && steps < 1000) begin
        opc = ref_mem[pc];
        opd = ref_mem[pc + 16'd1];
        val = opc[2] ? ref_mem[{8'h00, opd}] : opd;   // Zero page or immediate
        steps++;
        if (opc[4:0] == 5'b10000) begin
            case (opc[7:6])                 // Flag select
                2'b00:   flag = mn;
                2'b01:   flag = mv;
                2'b10:   flag = mc;
                default: flag = mz;
            endcase
            pc = pc + 16'd2;
            if (flag == opc[5]) pc = pc + {{8{opd[7]}}, opd};
        end else if (opc == 8'h4c) begin
            done = ({ref_mem[pc + 16'd2], opd} == pc);   // Jump to itself ends run
            pc   = {ref_mem[pc + 16'd2], opd};
        end else begin
            case (opc)
                8'ha9, 8'ha5: begin ma = val; set_nz(ma); end
                8'ha2, 8'ha6: begin mx = val; set_nz(mx); end
                8'ha0, 8'ha4: begin my = val; set_nz(my); end
                8'h85: store_byte(opd, ma);
                8'h86: store_byte(opd, mx);
                8'h84: store_byte(opd, my);
                8'h09, 8'h05: begin ma = ma | val; set_nz(ma); end
                8'h29, 8'h25: begin ma = ma & val; set_nz(ma); end
                8'h49, 8'h45: begin ma = ma ^ val; set_nz(ma); end
                8'h69, 8'h65: add_carry(val);
                8'he9, 8'he5: add_carry(~val);
                8'hc9, 8'hc5: begin
                    s  = {1'b0, ma} + {1'b0, ~val} + 9'd1;
                    mc = s[8];          // No borrow when A >= operand
                    set_nz(s[7:0]);
                end
                8'he8: begin mx = mx + 8'd1; set_nz(mx); end
                8'hc8: begin my = my + 8'd1; set_nz(my); end
                8'hca: begin mx = mx - 8'd1; set_nz(mx); end
                8'h88: begin my = my - 8'd1; set_nz(my); end
                8'haa: begin mx = ma; set_nz(mx); end
                8'ha8: begin my = ma; set_nz(my); end
                8'h8a: begin ma = mx; set_nz(ma); end
                8'h98: begin ma = my; set_nz(ma); end
                8'h18: mc = 1'b0;
                8'h38: mc = 1'b1;
                default: ;
            endcase
            // Implied opcodes end in 8 or A
            pc = pc + ((opc[3:0] == 4'h8 || opc[3:0] == 4'ha) ? 16'd1 : 16'd2);
        end
    end
    if (!done) fail_run("reference model never reached the final jump loop");
endtask

// File: tb_cpu_top.sv
/* Testbench top for cpu_top with random program image, synchronous memory,
   write checker against the reference model and timeouts */
`default_nettype none

module tb_cpu_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_INSTRS = 200;   // Generated instructions before the final JMP

    logic           clk;
    logic           reset;
    cpu_pkg::byte_t di;
    cpu_pkg::addr_t ab;
    cpu_pkg::byte_t data_out;
    logic           we;

    cpu_pkg::byte_t mem [0:65535];
    cpu_pkg::addr_t ab_q;               // Address sampled at the last rising edge
    cpu_pkg::addr_t gen_pc;
    cpu_pkg::addr_t loop_addr;          // Final JMP to itself
    cpu_pkg::addr_t exp_addr [$];
    cpu_pkg::byte_t exp_data [$];
    int             exp_total;
    int             write_count = 0;

    cpu_pkg::byte_t load_ops [6]  = '{8'ha9, 8'ha2, 8'ha0, 8'ha5, 8'ha6, 8'ha4};
    cpu_pkg::byte_t store_ops [3] = '{8'h85, 8'h86, 8'h84};
    cpu_pkg::byte_t alu_ops [12]  = '{8'h09, 8'h29, 8'h49, 8'h69, 8'he9, 8'hc9,
                                      8'h05, 8'h25, 8'h45, 8'h65, 8'he5, 8'hc5};
    cpu_pkg::byte_t impl_ops [10] = '{8'he8, 8'hc8, 8'hca, 8'h88, 8'haa,
                                      8'ha8, 8'h8a, 8'h98, 8'h18, 8'h38};

    cpu_top i_cpu_top (
        .clk, .reset, .ab, .di, .data_out, .we
    );

    always #2 clk = ~clk;               // 4 ns period

    task automatic fail_run(input string msg);
        $display("ERROR: %s", msg);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    `include "tb_model.svh"

    function automatic cpu_pkg::byte_t rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic put_byte(input cpu_pkg::byte_t b);
        mem[gen_pc] = b;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic build_image();
        logic [31:0]    i;
        int             count;
        int             kind;
        int             idx;
        cpu_pkg::byte_t b;
        for (i = 0; i < 32'd65536; i++) begin
            mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'h5a;   // Background fill
        end
        for (i = 0; i < 32'd256; i++) begin
            mem[i[15:0]] = rand_byte();                // Random zero page
        end
        gen_pc = 16'h02f0;              // Program crosses into page 03
        count  = 0;
        while (count < PROG_INSTRS) begin
            kind = $urandom % 8;
            case (kind)
                0, 1: begin
                    idx = $urandom % 6;
                    put_byte(load_ops[idx]);
                end
                2, 3: begin
                    idx = $urandom % 3;
                    put_byte(store_ops[idx]);
                end
                4, 5: begin
                    idx = $urandom % 12;
                    put_byte(alu_ops[idx]);
                end
                6: begin
                    idx = $urandom % 10;
                    put_byte(impl_ops[idx]);
                end
                default: begin
                    b = rand_byte();
                    put_byte({b[7:5], 5'b10000});          // Any of eight branches
                    put_byte(b[0] ? 8'h02 : 8'h00);        // Skip filler or not
                    put_byte(8'h85);                       // Filler STA zp
                    count++;
                end
            endcase
            if (kind != 6) put_byte(rand_byte());          // Operand byte
            count++;
        end
        loop_addr = gen_pc;
        put_byte(8'h4c);
        put_byte(loop_addr[7:0]);
        put_byte(loop_addr[15:8]);
        mem[16'hfffc] = 8'hf0;          // Reset vector to program start
        mem[16'hfffd] = 8'h02;
        for (i = 0; i < 32'd65536; i++) begin
            ref_mem[i[15:0]] = mem[i[15:0]];
        end
    endtask

    // Synchronous memory with read data valid in the cycle after the address
    always @(posedge clk) begin
        ab_q <= ab;
        if (!reset && we) begin         // Each store against the model list
            if (exp_addr.size() == 0) fail_run("core wrote more bytes than expected");
            check_value("ab", ab, exp_addr.pop_front());
            check_value("data_out", {8'h00, data_out}, {8'h00, exp_data.pop_front()});
            mem[ab] <= data_out;
            write_count++;
        end
    end

    always @(negedge clk) begin
        di <= mem[ab_q];
    end

    task automatic verify_first_fetch();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((ab_q == 16'hfffc || ab_q == 16'hfffd) && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 10) fail_run("core never left the reset vector");
        check_value("ab", ab_q, {mem[16'hfffd], mem[16'hfffc]});
    endtask

    task automatic drain_expected_writes();
        int cycles;
        cycles = 0;
        while (write_count < exp_total && cycles < 20 * PROG_INSTRS) begin
            @(negedge clk);
            cycles++;
        end
        if (write_count < exp_total) fail_run("timed out waiting for expected writes");
    endtask

    task automatic confirm_final_loop();
        int cycles;
        int hits;
        cycles = 0;
        hits   = 0;
        while (hits < 3 && cycles < 20 * PROG_INSTRS) begin
            @(negedge clk);
            if (ab_q == loop_addr) hits++;
            cycles++;
        end
        if (hits < 3) fail_run("core never settled in the final jump loop");
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        di    = 8'h00;
        void'($urandom(32'hc6b3));
        build_image();
        run_model();
        exp_total = exp_addr.size();
        $display("Program ends at %h, %0d writes expected", loop_addr, exp_total);
        repeat (5) begin
            @(negedge clk);
            check_value("we", {15'd0, we}, 16'h0000);
        end
        reset = 1'b0;
        verify_first_fetch();
        drain_expected_writes();
        confirm_final_loop();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
cpu_pkg.sv
instr_decode.sv
cpu_sequencer.sv
address_unit.sv
alu.sv
reg_file.sv
cpu_top.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu_top testbench with Verilator

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_cpu_top -o sim_cpu_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "Simulation passed, log in $LOG"
    exit 0
fi
echo "Simulation did not pass, log in $LOG"
exit 1
